// ==== tx_rst_pkg.sv ====
/* TX reset sequencer package
   Lane count, synchronizer depth, phase timing and the lane state type */
package tx_rst_pkg;

    ////////////////////////////////////////////////////////////
    // Quad geometry
    ////////////////////////////////////////////////////////////

    // Every lane of the quad is always present
    localparam int unsigned NUM_LANES = 4;

    // Flops in each level synchronizer
    localparam int unsigned SYNC_STAGES = 2;

    ////////////////////////////////////////////////////////////
    // Lock debounce
    ////////////////////////////////////////////////////////////

    // High samples of lock needed before it is trusted
    localparam int unsigned LOCK_DEB_CYCLES = 20;
    localparam int unsigned LOCK_DEB_W      = 5;

    ////////////////////////////////////////////////////////////
    // Reset phase timing
    ////////////////////////////////////////////////////////////

    // Minimum PMA reset hold in clk cycles
    localparam int unsigned PMA_RST_CYCLES = 16;
    // PCS reset hold once lock is debounced
    localparam int unsigned PCS_RST_CYCLES = 8;
    localparam int unsigned PHASE_CNT_W    = 5;

    // Lane sequence, in the order it is walked
    typedef enum logic [1:0] {
        ST_PMA_RST   = 2'd0,
        ST_WAIT_LOCK = 2'd1,
        ST_PCS_RST   = 2'd2,
        ST_DONE      = 2'd3
    } txlane_state_e;

endpackage

// ==== tx_rst_sync.sv ====
/* Level synchronizer
   Resamples one asynchronous level into clk, with a synchronous clear */
`timescale 1ns/1ps

module tx_rst_sync
    import tx_rst_pkg::*;
(
    input  logic clk,
    input  logic i_rst_n,
    input  logic i_async,
    output logic o_sync
);

    // Shift chain, stage 0 takes the raw level
    logic [SYNC_STAGES-1:0] sync_q;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], i_async};
        end
    end

    // Last stage is the only one safe to use
    assign o_sync = sync_q[SYNC_STAGES-1];

endmodule

// ==== pll_lock_debounce.sv ====
/* PLL lock debounce
   Lock must stay high for a run of samples before it is passed on */
`timescale 1ns/1ps

module pll_lock_debounce
    import tx_rst_pkg::*;
(
    input  logic clk,
    input  logic i_rst_n,
    input  logic i_lock,
    output logic o_lock_deb
);

    ////////////////////////////////////////////////////////////
    // High-run counter
    ////////////////////////////////////////////////////////////

    logic [LOCK_DEB_W-1:0] high_cnt_q;
    logic                  cnt_full;
    logic                  cnt_last;

    // Saturates once the run is long enough
    assign cnt_full = (high_cnt_q == LOCK_DEB_W'(LOCK_DEB_CYCLES));
    // Sample that completes the run
    assign cnt_last = (high_cnt_q == LOCK_DEB_W'(LOCK_DEB_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            high_cnt_q <= '0;
        end else if (!i_lock) begin
            // Any low sample restarts the run
            high_cnt_q <= '0;
        end else if (!cnt_full) begin
            high_cnt_q <= high_cnt_q + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Debounced flag
    ////////////////////////////////////////////////////////////

    // Rises only on a full run, falls on the first low sample
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_lock_deb <= 1'b0;
        end else if (!i_lock) begin
            o_lock_deb <= 1'b0;
        end else if (cnt_last) begin
            o_lock_deb <= 1'b1;
        end
    end

endmodule

// ==== txlane_rst_fsm.sv ====
/* TX lane reset sequencer
   Walks PMA reset, lock wait and PCS reset, then flags the lane done */
`timescale 1ns/1ps

module txlane_rst_fsm
    import tx_rst_pkg::*;
(
    input  logic clk,
    input  logic i_rst_n,
    input  logic i_lock_deb,
    output logic o_tx_pma_rst,
    output logic o_pcs_tx_rst,
    output logic o_txlane_done
);

    ////////////////////////////////////////////////////////////
    // State and phase timer
    ////////////////////////////////////////////////////////////

    txlane_state_e          state_q;
    txlane_state_e          state_d;
    logic [PHASE_CNT_W-1:0] phase_q;
    logic [PHASE_CNT_W-1:0] phase_d;
    logic                   pma_last;
    logic                   pcs_last;

    // Final cycle of each timed phase
    assign pma_last = (phase_q == PHASE_CNT_W'(PMA_RST_CYCLES - 1));
    assign pcs_last = (phase_q == PHASE_CNT_W'(PCS_RST_CYCLES - 1));

    ////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        phase_d = phase_q;

        case (state_q)
            ST_PMA_RST: begin
                // Fixed hold, lock is not looked at here
                if (pma_last) begin
                    state_d = ST_WAIT_LOCK;
                    phase_d = '0;
                end else begin
                    phase_d = phase_q + 1'b1;
                end
            end

            ST_WAIT_LOCK: begin
                // Open ended wait for a clean lock
                if (i_lock_deb) begin
                    state_d = ST_PCS_RST;
                    phase_d = '0;
                end
            end

            ST_PCS_RST: begin
                if (!i_lock_deb) begin
                    // Lost lock so redo the PMA reset
                    state_d = ST_PMA_RST;
                    phase_d = '0;
                end else if (pcs_last) begin
                    state_d = ST_DONE;
                    phase_d = '0;
                end else begin
                    phase_d = phase_q + 1'b1;
                end
            end

            ST_DONE: begin
                if (!i_lock_deb) begin
                    state_d = ST_PMA_RST;
                    phase_d = '0;
                end
            end

            default: begin
                state_d = ST_PMA_RST;
                phase_d = '0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // State registers
    ////////////////////////////////////////////////////////////

    // Clear is lane enable, so the lane idles in PMA reset
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state_q <= ST_PMA_RST;
            phase_q <= '0;
        end else begin
            state_q <= state_d;
            phase_q <= phase_d;
        end
    end

    ////////////////////////////////////////////////////////////
    // Registered outputs
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_tx_pma_rst  <= 1'b1;
            o_pcs_tx_rst  <= 1'b1;
            o_txlane_done <= 1'b0;
        end else begin
            case (state_q)
                ST_PMA_RST: begin
                    o_tx_pma_rst  <= 1'b1;
                    o_pcs_tx_rst  <= 1'b1;
                    o_txlane_done <= 1'b0;
                end
                ST_WAIT_LOCK,
                ST_PCS_RST: begin
                    // PMA released, PCS held until its phase ends
                    o_tx_pma_rst  <= 1'b0;
                    o_pcs_tx_rst  <= 1'b1;
                    o_txlane_done <= 1'b0;
                end
                ST_DONE: begin
                    o_tx_pma_rst  <= 1'b0;
                    o_pcs_tx_rst  <= 1'b0;
                    o_txlane_done <= 1'b1;
                end
                default: begin
                    o_tx_pma_rst  <= 1'b1;
                    o_pcs_tx_rst  <= 1'b1;
                    o_txlane_done <= 1'b0;
                end
            endcase
        end
    end

endmodule

// ==== hsst_tx_rst.sv ====
/* Quad TX reset sequencer
   Per lane PLL selection, input synchronizers, lock debounce and sequencing */
`timescale 1ns/1ps

module hsst_tx_rst
    import tx_rst_pkg::*;
(
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic [NUM_LANES-1:0] i_txlane_rst,
    input  logic                 i_hpll_done,
    input  logic [NUM_LANES-1:0] i_lpll_done,
    input  logic [NUM_LANES-1:0] i_pll_tx_sel,
    input  logic [NUM_LANES-1:0] i_pll_lock_tx,
    output logic [NUM_LANES-1:0] o_tx_pma_rst,
    output logic [NUM_LANES-1:0] o_pcs_tx_rst,
    output logic [NUM_LANES-1:0] o_txlane_done
);

    ////////////////////////////////////////////////////////////
    // Per-lane nets
    ////////////////////////////////////////////////////////////

    // PLL done flag chosen for each lane
    logic [NUM_LANES-1:0] pll_ready;
    // Synchronized lane reset, active low
    logic [NUM_LANES-1:0] lane_rstn;
    logic [NUM_LANES-1:0] lock_sync;
    logic [NUM_LANES-1:0] lock_deb;
    // Lane may run its sequence
    logic [NUM_LANES-1:0] lane_en;

    for (genvar n = 0; n < NUM_LANES; n++) begin : g_lane

        // Own LPLL when selected, shared HPLL otherwise
        assign pll_ready[n] = i_pll_tx_sel[n] ? i_lpll_done[n] : i_hpll_done;

        assign lane_en[n] = lane_rstn[n] & pll_ready[n];

        ////////////////////////////////////////////////////////
        // Synchronizers
        ////////////////////////////////////////////////////////

        // Request is active high at the port
        tx_rst_sync u_rstn_sync (
            .clk     (clk),
            .i_rst_n (i_rst_n),
            .i_async (~i_txlane_rst[n]),
            .o_sync  (lane_rstn[n])
        );

        // Lock is ignored while the lane is held in reset
        tx_rst_sync u_lock_sync (
            .clk     (clk),
            .i_rst_n (lane_rstn[n]),
            .i_async (i_pll_lock_tx[n]),
            .o_sync  (lock_sync[n])
        );

        ////////////////////////////////////////////////////////
        // Debounce and sequencer
        ////////////////////////////////////////////////////////

        pll_lock_debounce u_lock_deb (
            .clk        (clk),
            .i_rst_n    (lane_en[n]),
            .i_lock     (lock_sync[n]),
            .o_lock_deb (lock_deb[n])
        );

        txlane_rst_fsm u_fsm (
            .clk           (clk),
            .i_rst_n       (lane_en[n]),
            .i_lock_deb    (lock_deb[n]),
            .o_tx_pma_rst  (o_tx_pma_rst[n]),
            .o_pcs_tx_rst  (o_pcs_tx_rst[n]),
            .o_txlane_done (o_txlane_done[n])
        );

    end

endmodule

// ==== hsst_tx_rst_checker.sv ====
/* TX reset sequencer checker
   Output consistency rules, bound onto the quad top level */
`timescale 1ns/1ps

module hsst_tx_rst_checker
    import tx_rst_pkg::*;
(
    input logic                 clk,
    input logic                 i_rst_n,
    input logic [NUM_LANES-1:0] o_tx_pma_rst,
    input logic [NUM_LANES-1:0] o_pcs_tx_rst,
    input logic [NUM_LANES-1:0] o_txlane_done
);

    // Failed assertions so far, polled by the testbench each cycle
    int         fail_cnt = 0;
    // Cycles spent in reset, outputs are settled from the third one
    logic [1:0] rst_age  = '0;

    always @(posedge clk) begin
        if (i_rst_n) begin
            rst_age <= '0;
        end else if (rst_age != 2'd3) begin
            rst_age <= rst_age + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Output rules
    ////////////////////////////////////////////////////////////

    // A done lane has both resets released
    a_done_no_rst: assert property (@(posedge clk) disable iff (!i_rst_n)
        (o_txlane_done & (o_tx_pma_rst | o_pcs_tx_rst)) == '0)
        else begin
            $error("done lane still has a reset asserted");
            fail_cnt++;
        end

    // PCS stays in reset whenever PMA is
    a_pma_implies_pcs: assert property (@(posedge clk) disable iff (!i_rst_n)
        (o_tx_pma_rst & ~o_pcs_tx_rst) == '0)
        else begin
            $error("PMA reset high with PCS reset low");
            fail_cnt++;
        end

    a_reset_values: assert property (@(posedge clk)
        (!i_rst_n && rst_age >= 2'd2) |->
        (o_tx_pma_rst == '1 && o_pcs_tx_rst == '1 && o_txlane_done == '0))
        else begin
            $error("outputs not at reset values during reset");
            fail_cnt++;
        end

endmodule

// ==== tb_hsst_tx_rst.sv ====
/* Quad TX reset sequencer testbench
   LFSR stimulus checked against a per-lane timing model */
`timescale 1ns/1ps

module tb_hsst_tx_rst
    import tx_rst_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int RST_CYCLES   = 4;
    // Lock held to done, and loss of enable to done low
    localparam int DONE_BOUND   = 80;
    localparam int DROP_BOUND   = 6;
    // Done cannot rise sooner than this after a fresh lock run
    localparam int EARLY_LIMIT  = 25;
    localparam int SEL_CYCLES   = 300;
    localparam int PULSE_ROUNDS = 40;
    localparam int PULSE_MAX    = 9;
    localparam int NOISE_CYCLES = 700;
    localparam int TEST_CYCLES  = RST_CYCLES + 2 * SEL_CYCLES + 2 * PULSE_ROUNDS * PULSE_MAX
                                  + NOISE_CYCLES + 6 * DONE_BOUND;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic                 clk;
    logic                 rst_n;
    logic                 hpll_done;
    logic [NUM_LANES-1:0] txlane_rst;
    logic [NUM_LANES-1:0] lpll_done;
    logic [NUM_LANES-1:0] pll_tx_sel;
    logic [NUM_LANES-1:0] pll_lock_tx;
    logic [NUM_LANES-1:0] tx_pma_rst;
    logic [NUM_LANES-1:0] pcs_tx_rst;
    logic [NUM_LANES-1:0] txlane_done;

    // Lane model: locked run, disabled run, settled done or -1 in transit
    int          lk_cnt  [NUM_LANES];
    int          dis_cnt [NUM_LANES];
    int          pred    [NUM_LANES];
    int          cycle_cnt = 0;
    logic [15:0] lfsr_q    = 16'd43;

    hsst_tx_rst i_dut (
        .clk           (clk),
        .i_rst_n       (rst_n),
        .i_txlane_rst  (txlane_rst),
        .i_hpll_done   (hpll_done),
        .i_lpll_done   (lpll_done),
        .i_pll_tx_sel  (pll_tx_sel),
        .i_pll_lock_tx (pll_lock_tx),
        .o_tx_pma_rst  (tx_pma_rst),
        .o_pcs_tx_rst  (pcs_tx_rst),
        .o_txlane_done (txlane_done)
    );

    bind hsst_tx_rst hsst_tx_rst_checker i_chk (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .o_tx_pma_rst  (o_tx_pma_rst),
        .o_pcs_tx_rst  (o_pcs_tx_rst),
        .o_txlane_done (o_txlane_done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            fail_now($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int unsigned rand_bits(input int n);
        int unsigned r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            r = (r << 1) | lfsr_q[0];
        end
        return r;
    endfunction

    task automatic fail_now(input string what);
        $display("Error at %0d ns: %s", $time, what);
        $display("TEST FAIL");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("Fail at %0d ns: %s expected %0h got %0h", $time, name, exp, act);
            $display("TEST FAIL");
            $fatal(1, "Output mismatch");
        end
    endtask

    // Count the inputs the DUT samples on this edge
    task automatic update_model();
        logic ready;
        for (int n = 0; n < NUM_LANES; n++) begin
            ready = pll_tx_sel[n] ? lpll_done[n] : hpll_done;
            if (rst_n && !txlane_rst[n] && ready && pll_lock_tx[n]) begin
                lk_cnt[n]++;
                dis_cnt[n] = 0;
            end else begin
                lk_cnt[n] = 0;
                dis_cnt[n]++;
            end
            if (dis_cnt[n] >= DROP_BOUND) begin
                pred[n] = 0;
            end else if (lk_cnt[n] >= DONE_BOUND) begin
                pred[n] = 1;
            end else if (!(pred[n] == 0 && lk_cnt[n] < EARLY_LIMIT)) begin
                pred[n] = -1;
            end
        end
    endtask

    task automatic check_outputs();
        if (i_dut.i_chk.fail_cnt != 0) begin
            fail_now("an output rule of the checker was violated");
        end
        for (int n = 0; n < NUM_LANES; n++) begin
            if (pred[n] >= 0) begin
                check_val($sformatf("o_txlane_done[%0d]", n), pred[n], txlane_done[n]);
            end
            if (txlane_done[n] === 1'b1) begin
                check_val($sformatf("o_tx_pma_rst[%0d]", n), 0, tx_pma_rst[n]);
                check_val($sformatf("o_pcs_tx_rst[%0d]", n), 0, pcs_tx_rst[n]);
            end
        end
    endtask

    // Model on the rising edge, outputs checked on the falling edge
    task automatic tick();
        @(posedge clk);
        update_model();
        @(negedge clk);
        check_outputs();
    endtask

    task automatic wait_done(input logic [NUM_LANES-1:0] mask);
        int waited;
        waited = 0;
        while ((txlane_done & mask) != mask) begin
            if (waited == DONE_BOUND) begin
                fail_now($sformatf("lanes %b not done within %0d cycles", mask, DONE_BOUND));
            end else begin
                tick();
                waited++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rst_n       = 1'b0;
        hpll_done   = 1'b0;
        txlane_rst  = '1;
        lpll_done   = '0;
        pll_tx_sel  = '0;
        pll_lock_tx = '0;
        for (int n = 0; n < NUM_LANES; n++) begin
            lk_cnt[n]  = 0;
            dis_cnt[n] = 0;
            pred[n]    = -1;
        end
        repeat (RST_CYCLES) tick();
        rst_n = 1'b1;
        check_val("o_tx_pma_rst", {NUM_LANES{1'b1}}, tx_pma_rst);
        check_val("o_pcs_tx_rst", {NUM_LANES{1'b1}}, pcs_tx_rst);
        check_val("o_txlane_done", 0, txlane_done);

        // All lanes released with PLLs ready and lock high
        txlane_rst  = '0;
        hpll_done   = 1'b1;
        lpll_done   = '1;
        pll_tx_sel  = NUM_LANES'(rand_bits(NUM_LANES));
        pll_lock_tx = '1;
        wait_done('1);
        check_val("o_tx_pma_rst", 0, tx_pma_rst);
        check_val("o_pcs_tx_rst", 0, pcs_tx_rst);

        // Lane 0 on its own LPLL, which is down, while HPLL toggles
        pll_tx_sel = '1;
        lpll_done  = 4'b1110;
        repeat (SEL_CYCLES) begin
            hpll_done = 1'(rand_bits(1));
            tick();
        end
        check_val("o_txlane_done", 4'b1110, txlane_done);

        // Lane 0 on HPLL, which is down, while its LPLL toggles
        pll_tx_sel = 4'b1110;
        hpll_done  = 1'b0;
        repeat (SEL_CYCLES) begin
            lpll_done[0] = 1'(rand_bits(1));
            tick();
        end
        check_val("o_txlane_done", 4'b1110, txlane_done);
        hpll_done = 1'b1;
        wait_done('1);

        // Lane 1 loses lock, then sees only short lock pulses
        pll_lock_tx[1] = 1'b0;
        repeat (DROP_BOUND) tick();
        check_val("o_txlane_done[1]", 0, txlane_done[1]);
        check_val("o_tx_pma_rst[1]", 1, tx_pma_rst[1]);
        repeat (PULSE_ROUNDS) begin
            pll_lock_tx[1] = 1'b1;
            repeat (1 + rand_bits(4) % PULSE_MAX) tick();
            pll_lock_tx[1] = 1'b0;
            repeat (1 + rand_bits(3)) tick();
        end
        pll_lock_tx[1] = 1'b1;
        wait_done('1);

        // Reset request noise on lane 2 only
        repeat (NOISE_CYCLES) begin
            txlane_rst[2] = (rand_bits(2) == 0);
            tick();
        end
        check_val("o_txlane_done[3,1:0]", 4'b1011, txlane_done & 4'b1011);
        txlane_rst = '0;
        wait_done('1);

        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== tb.f ====
tx_rst_pkg.sv
tx_rst_sync.sv
pll_lock_debounce.sv
txlane_rst_fsm.sv
hsst_tx_rst.sv
hsst_tx_rst_checker.sv
tb_hsst_tx_rst.sv

// ==== Bender.yml ====
package:
  name: hsst_tx_rst

sources:
  - tx_rst_pkg.sv
  - tx_rst_sync.sv
  - pll_lock_debounce.sv
  - txlane_rst_fsm.sv
  - hsst_tx_rst.sv
  - target: test
    files:
      - hsst_tx_rst_checker.sv
      - tb_hsst_tx_rst.sv
